// File: common/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address and data word widths
`define ADDR_BITS   32
`define WORD_BITS   64

// address split as tag | index | offset
`define OFFSET_BITS 5
`define INDEX_BITS  6
`define TAG_BITS    21

// geometry of the two-way store
`define CACHE_SETS  64
// words per line, also beats per refill burst
`define LINE_BEATS  4
`define LINE_BITS   256

`endif

// File: common/cache_pkg.sv
package cache_pkg;

  `include "cache_params.svh"

  // address fields as the cache decodes them
  typedef struct packed {
    logic [`TAG_BITS-1:0]    tag;
    logic [`INDEX_BITS-1:0]  index;
    logic [`OFFSET_BITS-1:0] offset;
  } addrFields_t;

  // same word seen whole or split into fields
  typedef union packed {
    logic [`ADDR_BITS-1:0] raw;
    addrFields_t           f;
  } cacheAddr_u;

  // pipeline read request
  typedef struct packed {
    logic       valid;
    cacheAddr_u addr;
  } cpuReq_t;

  // one refill beat from the memory side
  typedef struct packed {
    logic                  dataValid;
    logic                  last;
    logic [`WORD_BITS-1:0] data;
  } memBeat_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL,
    FILL,
    REPLY
  } cacheState_e;

endpackage

// File: rtl/beatCounter.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module beatCounter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            refillEn_i,
  input  logic                            beatValid_i,
  input  logic                            beatLast_i,
  output logic [$clog2(`LINE_BEATS)-1:0] beatIdx_o,
  output logic                            lineDone_o
);

  logic beatTaken;

  // a beat only counts while refilling
  assign beatTaken  = refillEn_i && beatValid_i;
  assign lineDone_o = beatTaken && beatLast_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatIdx_o <= '0;
    end else if (lineDone_o) begin
      // ready for the next refill
      beatIdx_o <= '0;
    end else if (beatTaken) begin
      beatIdx_o <= beatIdx_o + 1'b1;
    end
  end

  // memory side must send exactly one full line
  lastOnFinalBeat: assert property (@(posedge clk) disable iff (!rst_n)
    lineDone_o |-> (beatIdx_o == ($clog2(`LINE_BEATS))'(`LINE_BEATS - 1)));

endmodule

// File: rtl/tagStore.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module tagStore (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::cacheAddr_u lookupAddr_i,
  input  cache_pkg::cacheAddr_u reqAddr_i,
  input  logic                  acceptEn_i,
  input  logic                  fillEn_i,
  output logic                  hit_o,
  output logic                  hitWay_o,
  output logic                  victimWay_o
);

  logic [`TAG_BITS-1:0]         tagArr [2][`CACHE_SETS];
  logic [1:0][`CACHE_SETS-1:0]  validArr;
  // per set bit naming the least recently used way
  logic [`CACHE_SETS-1:0]       lruArr;

  logic [`TAG_BITS-1:0] tagQ [2];
  logic [1:0]           validQ;
  logic                 lookupQ;
  logic [1:0]           wayHit;

  // tag write on fill into the victim way
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[victimWay_o][reqAddr_i.f.index] <= reqAddr_i.f.tag;
    end
  end

  // set read registered at acceptance
  always_ff @(posedge clk) begin
    if (acceptEn_i) begin
      for (int w = 0; w < 2; w++) begin
        tagQ[w] <= tagArr[w][lookupAddr_i.f.index];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ  <= '0;
      lookupQ <= 1'b0;
    end else begin
      // high exactly in the cycle after an acceptance
      lookupQ <= acceptEn_i;
      if (acceptEn_i) begin
        validQ <= {validArr[1][lookupAddr_i.f.index], validArr[0][lookupAddr_i.f.index]};
      end
    end
  end

  // compare against the latched request tag
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w] && (tagQ[w] == reqAddr_i.f.tag);
    end
  end

  assign hit_o       = lookupQ && (|wayHit);
  assign hitWay_o    = wayHit[1];
  assign victimWay_o = lruArr[reqAddr_i.f.index];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
      lruArr   <= '0;
    end else if (hit_o) begin
      // point away from the way just used
      lruArr[reqAddr_i.f.index] <= ~hitWay_o;
    end else if (fillEn_i) begin
      validArr[victimWay_o][reqAddr_i.f.index] <= 1'b1;
      lruArr[reqAddr_i.f.index]               <= ~victimWay_o;
    end
  end

  // fills only follow misses so a tag never sits in both ways
  noDoubleHit: assert property (@(posedge clk) disable iff (!rst_n)
    lookupQ |-> !(wayHit[0] && wayHit[1]));

endmodule

// File: rtl/lineStore.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module lineStore (
  input  logic                            clk,
  input  cache_pkg::cacheAddr_u           lookupAddr_i,
  input  cache_pkg::cacheAddr_u           reqAddr_i,
  input  logic                            acceptEn_i,
  input  cache_pkg::memBeat_t             memBeat_i,
  input  logic                            refillEn_i,
  input  logic [$clog2(`LINE_BEATS)-1:0] beatIdx_i,
  input  logic                            fillEn_i,
  input  logic                            replyEn_i,
  input  logic                            hitWay_i,
  input  logic                            victimWay_i,
  output logic [`WORD_BITS-1:0]           rdData_o
);

  logic [`LINE_BITS-1:0] wayMem [2][`CACHE_SETS];
  logic [`LINE_BITS-1:0] rdLine [2];
  logic [`LINE_BITS-1:0] refillBuf;
  logic [`LINE_BITS-1:0] srcLine;
  logic [$clog2(`LINE_BEATS)-1:0] wordSel;

  // data arrays
  // read at acceptance and write in fill never share a cycle
  always_ff @(posedge clk) begin
    if (acceptEn_i) begin
      for (int w = 0; w < 2; w++) begin
        rdLine[w] <= wayMem[w][lookupAddr_i.f.index];
      end
    end
    if (fillEn_i) begin
      wayMem[victimWay_i][reqAddr_i.f.index] <= refillBuf;
    end
  end

  // refill buffer
  // beats land at the counter position
  always_ff @(posedge clk) begin
    if (refillEn_i && memBeat_i.dataValid) begin
      refillBuf[beatIdx_i*`WORD_BITS +: `WORD_BITS] <= memBeat_i.data;
    end
  end

  // miss replies come from the buffer
  // since the arrays were read before the fill
  assign srcLine = replyEn_i ? refillBuf : rdLine[hitWay_i];

  // word position inside the line
  assign wordSel  = reqAddr_i.f.offset[`OFFSET_BITS-1 -: $clog2(`LINE_BEATS)];
  assign rdData_o = srcLine[wordSel*`WORD_BITS +: `WORD_BITS];

endmodule

// File: rtl/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::cpuReq_t    cpuReq_i,
  input  logic                  hit_i,
  input  logic                  lineDone_i,
  input  logic                  memRdReady_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  memRdValid_o,
  output cache_pkg::cacheAddr_u reqAddr_o,
  output logic                  acceptEn_o,
  output logic                  refillEn_o,
  output logic                  fillEn_o,
  output logic                  replyEn_o
);

  cache_pkg::cacheState_e curState;
  cache_pkg::cacheState_e nextState;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= cache_pkg::IDLE;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      cache_pkg::IDLE: begin
        if (cpuReq_i.valid) begin
          nextState = cache_pkg::LOOKUP;
        end
      end
      cache_pkg::LOOKUP: begin
        // a hit may chain straight into the next lookup
        if (!hit_i) begin
          nextState = cache_pkg::MISS;
        end else if (!cpuReq_i.valid) begin
          nextState = cache_pkg::IDLE;
        end
      end
      cache_pkg::MISS: begin
        if (memRdReady_i) begin
          nextState = cache_pkg::REFILL;
        end
      end
      cache_pkg::REFILL: begin
        if (lineDone_i) begin
          nextState = cache_pkg::FILL;
        end
      end
      cache_pkg::FILL:  nextState = cache_pkg::REPLY;
      cache_pkg::REPLY: nextState = cache_pkg::IDLE;
      default:          nextState = cache_pkg::IDLE;
    endcase
  end

  // take requests when idle or right behind a hit
  assign addrOk_o   = (curState == cache_pkg::IDLE) ||
                      ((curState == cache_pkg::LOOKUP) && hit_i);
  assign acceptEn_o = cpuReq_i.valid && addrOk_o;

  // request address held for the whole access
  always_ff @(posedge clk) begin
    if (acceptEn_o) begin
      reqAddr_o <= cpuReq_i.addr;
    end
  end

  // issue cycle only when memory is ready
  assign memRdValid_o = (curState == cache_pkg::MISS) && memRdReady_i;
  assign refillEn_o   = (curState == cache_pkg::REFILL);
  assign fillEn_o     = (curState == cache_pkg::FILL);
  assign replyEn_o    = (curState == cache_pkg::REPLY);
  // hit answers in lookup, miss answers from the buffer in reply
  assign dataOk_o     = ((curState == cache_pkg::LOOKUP) && hit_i) || replyEn_o;

  // tag compare strobe must line up with the lookup state
  hitOnlyInLookup: assert property (@(posedge clk) disable iff (!rst_n)
    hit_i |-> (curState == cache_pkg::LOOKUP));

endmodule

// File: rtl/cacheTop.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cacheTop (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cache_pkg::cpuReq_t     cpuReq_i,
  output logic                   addrOk_o,
  output logic                   dataOk_o,
  output logic [`WORD_BITS-1:0]  rdData_o,
  output logic                   memRdValid_o,
  input  logic                   memRdReady_i,
  output logic [`ADDR_BITS-1:0]  memAddr_o,
  input  cache_pkg::memBeat_t    memBeat_i
);

  cache_pkg::cacheAddr_u reqAddr;
  logic acceptEn;
  logic refillEn;
  logic fillEn;
  logic replyEn;
  logic hit;
  logic hitWay;
  logic victimWay;
  logic lineDone;
  logic [$clog2(`LINE_BEATS)-1:0] beatIdx;

  cacheCtrl ctrl0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpuReq_i     (cpuReq_i),
    .hit_i        (hit),
    .lineDone_i   (lineDone),
    .memRdReady_i (memRdReady_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .memRdValid_o (memRdValid_o),
    .reqAddr_o    (reqAddr),
    .acceptEn_o   (acceptEn),
    .refillEn_o   (refillEn),
    .fillEn_o     (fillEn),
    .replyEn_o    (replyEn)
  );

  beatCounter beats0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .refillEn_i  (refillEn),
    .beatValid_i (memBeat_i.dataValid),
    .beatLast_i  (memBeat_i.last),
    .beatIdx_o   (beatIdx),
    .lineDone_o  (lineDone)
  );

  // lookups use the incoming address, compares the latched one
  tagStore tags0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookupAddr_i (cpuReq_i.addr),
    .reqAddr_i    (reqAddr),
    .acceptEn_i   (acceptEn),
    .fillEn_i     (fillEn),
    .hit_o        (hit),
    .hitWay_o     (hitWay),
    .victimWay_o  (victimWay)
  );

  lineStore lines0 (
    .clk          (clk),
    .lookupAddr_i (cpuReq_i.addr),
    .reqAddr_i    (reqAddr),
    .acceptEn_i   (acceptEn),
    .memBeat_i    (memBeat_i),
    .refillEn_i   (refillEn),
    .beatIdx_i    (beatIdx),
    .fillEn_i     (fillEn),
    .replyEn_i    (replyEn),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .rdData_o     (rdData_o)
  );

  // line aligned refill address
  assign memAddr_o = {reqAddr.f.tag, reqAddr.f.index, {`OFFSET_BITS{1'b0}}};

endmodule

// File: tests/cacheTop_tb.sv
`timescale 1ns/1ps

`include "cache_params.svh"

module cacheTop_tb;

  logic                  clk;
  logic                  rst_n;
  cache_pkg::cpuReq_t    cpuReq;
  logic                  addrOk;
  logic                  dataOk;
  logic [`WORD_BITS-1:0] rdData;
  logic                  memRdValid;
  logic                  memRdReady;
  logic [`ADDR_BITS-1:0] memAddr;
  cache_pkg::memBeat_t   memBeat;

  // file image: entry count, then address, hit flag and word per entry
  logic [63:0] tdMem [0:127];
  int          numEntries;
  int          timeoutLimit;
  integer      seed = 32'h67cf_c0a7;

  // scoreboard state, owned by the monitor
  int pendQ[$];
  int acceptQ[$];
  int acceptCount;
  int doneCount;
  int cycleCnt;
  int issueCount;
  bit timedOut;
  int wordErrs;
  int hitErrs;
  int addrErrs;
  int okErrs;
  int otherErrs;

  cacheTop dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpuReq_i     (cpuReq),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRdValid_o (memRdValid),
    .memRdReady_i (memRdReady),
    .memAddr_o    (memAddr),
    .memBeat_i    (memBeat)
  );

  function automatic logic [`ADDR_BITS-1:0] addrOf(input int i);
    return tdMem[1 + 3 * i][`ADDR_BITS-1:0];
  endfunction

  function automatic logic hitOf(input int i);
    return tdMem[2 + 3 * i][0];
  endfunction

  function automatic logic [`WORD_BITS-1:0] wordOf(input int i);
    return tdMem[3 + 3 * i];
  endfunction

  // memory content: address on top, its inverse below
  function automatic logic [`WORD_BITS-1:0] memWord(input logic [`ADDR_BITS-1:0] a);
    return {a, ~a};
  endfunction

  task automatic checkWord(input logic [`WORD_BITS-1:0] got, input logic [`WORD_BITS-1:0] exp,
                           input cache_pkg::cacheAddr_u addr);
    if (got !== exp) begin
      wordErrs++;
      $display("CHECK FAILED at %0t: word for %h is %h, expected %h", $time, addr.raw, got, exp);
    end
  endtask

  task automatic checkHit(input logic got, input logic exp, input cache_pkg::cacheAddr_u addr);
    if (got !== exp) begin
      hitErrs++;
      $display("CHECK FAILED at %0t: hit for %h is %b, expected %b", $time, addr.raw, got, exp);
    end
  endtask

  task automatic compareMemAddr(input logic [`ADDR_BITS-1:0] got,
                                input logic [`ADDR_BITS-1:0] exp);
    if (got !== exp) begin
      addrErrs++;
      $display("CHECK FAILED at %0t: line request to %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic checkAddrOk(input logic got, input logic exp);
    if (got !== exp) begin
      okErrs++;
      $display("CHECK FAILED at %0t: addrOk is %b, expected %b", $time, got, exp);
    end
  endtask

  initial begin : clockGen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : mainFlow
    int i;
    cpuReq = '0;
    rst_n  = 1'b0;
    $readmemh("tests/cache_testdata.txt", tdMem);
    numEntries   = int'(tdMem[0][31:0]);
    if (numEntries == 0) begin
      otherErrs++;
      $display("ERROR: test data file holds no entries");
    end
    timeoutLimit = numEntries * 40;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < numEntries; i++) begin
      cpuReq.valid    <= 1'b1;
      cpuReq.addr.raw <= addrOf(i);
      // held until an edge sees addrOk high
      @(posedge clk);
      while (!addrOk) begin
        @(posedge clk);
      end
      @(negedge clk);
    end
    cpuReq.valid <= 1'b0;
    wait (doneCount == numEntries);
    // a few idle cycles to catch stray replies
    repeat (4) @(posedge clk);
    $display("errors: %0d word, %0d hit, %0d address, %0d handshake, %0d other",
             wordErrs, hitErrs, addrErrs, okErrs, otherErrs);
    if (wordErrs + hitErrs + addrErrs + okErrs + otherErrs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // outputs sampled at the rising edge, before the DUT registers move
  initial begin : monitor
    int idx;
    int acc;
    bit expOk;
    cache_pkg::cacheAddr_u a;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        cycleCnt++;
        if (cycleCnt > timeoutLimit && doneCount < numEntries) begin
          timedOut = 1'b1;
        end
        // open when nothing is outstanding or a hit answers this cycle
        expOk = (pendQ.size() == 0) ||
                (hitOf(pendQ[0]) && (cycleCnt - acceptQ[0] == 1));
        checkAddrOk(addrOk, expOk);
        // misses block, so an issue belongs to the oldest access
        if (memRdValid) begin
          issueCount++;
          if (pendQ.size() == 0) begin
            otherErrs++;
            $display("ERROR at %0t: memory read issued with no access outstanding", $time);
          end else begin
            compareMemAddr(memAddr, addrOf(pendQ[0]) & 32'hffff_ffe0);
          end
        end
        if (dataOk) begin
          if (pendQ.size() == 0) begin
            otherErrs++;
            $display("ERROR at %0t: reply with no access outstanding", $time);
          end else begin
            idx   = pendQ.pop_front();
            acc   = acceptQ.pop_front();
            a.raw = addrOf(idx);
            checkWord(rdData, wordOf(idx), a);
            // hit means no line request between acceptance and reply
            checkHit(issueCount == 0, hitOf(idx), a);
            if (issueCount > 1) begin
              otherErrs++;
              $display("ERROR at %0t: %0d line requests for one access", $time, issueCount);
            end
            if (hitOf(idx) && cycleCnt - acc != 1) begin
              otherErrs++;
              $display("ERROR at %0t: hit answered %0d cycles after acceptance",
                       $time, cycleCnt - acc);
            end
            issueCount = 0;
            doneCount++;
          end
        end
        if (cpuReq.valid && addrOk) begin
          pendQ.push_back(acceptCount);
          acceptQ.push_back(cycleCnt);
          acceptCount++;
        end
      end
    end
  end

  // memory side with random ready and beat gaps
  initial begin : memResponder
    logic [31:0]           rnd;
    logic [`ADDR_BITS-1:0] burstBase;
    int                    beatNum;
    bit                    burstOn;
    memRdReady = 1'b0;
    memBeat    = '0;
    burstOn    = 1'b0;
    forever begin
      @(posedge clk);
      if (memRdValid) begin
        burstBase = memAddr;
        beatNum   = 0;
        burstOn   = 1'b1;
      end
      @(negedge clk);
      rnd = $random(seed);
      // ready about three cycles in four
      memRdReady        <= rnd[0] | rnd[1];
      memBeat.dataValid <= 1'b0;
      memBeat.last      <= 1'b0;
      if (burstOn && rnd[2]) begin
        memBeat.dataValid <= 1'b1;
        memBeat.last      <= (beatNum == `LINE_BEATS - 1);
        memBeat.data      <= memWord(burstBase + beatNum * 8);
        beatNum++;
        if (beatNum == `LINE_BEATS) begin
          burstOn = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    wait (timedOut);
    $display("ERROR: timeout after %0d cycles, %0d of %0d accesses answered",
             cycleCnt, doneCount, numEntries);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tests/cache_testdata.txt
// first word: entry count
// then per entry: byte address, expected hit flag, expected 64-bit word
00000013
00000020 0 00000020ffffffdf
00000028 1 00000028ffffffd7
00000030 1 00000030ffffffcf
00000038 1 00000038ffffffc7
00000040 0 00000040ffffffbf
00000058 1 00000058ffffffa7
00000820 0 00000820fffff7df
00000838 1 00000838fffff7c7
00000020 1 00000020ffffffdf
00001020 0 00001020ffffefdf
00001028 1 00001028ffffefd7
00000030 1 00000030ffffffcf
00000820 0 00000820fffff7df
00000828 1 00000828fffff7d7
00000038 1 00000038ffffffc7
00001038 0 00001038ffffefc7
00000048 1 00000048ffffffb7
00000050 1 00000050ffffffaf
00001030 1 00001030ffffefcf

// File: cacheTop.f
+incdir+common
common/cache_pkg.sv
rtl/beatCounter.sv
rtl/tagStore.sv
rtl/lineStore.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
tests/cacheTop_tb.sv

// File: Makefile
TOP = cacheTop_tb

all: run

build:
	verilator --binary --timing --assert -f cacheTop.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f cacheTop.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
